/* hw/i2s_pwm_pkg.sv */
package i2s_pwm_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Longest serial word the shift register can hold
    localparam int MAX_WORD_BITS = 32;
    // Shortest word accepted by the aligner
    localparam int MIN_WORD_BITS = 8;
    // Aligned sample width
    localparam int SAMPLE_BITS = 24;
    // PWM resolution, period is 2**PWM_BITS clk cycles
    localparam int PWM_BITS = 8;
    localparam int PWM_PERIOD = 2 ** PWM_BITS;
    // Bit count per word, saturates at all ones
    localparam int WORD_LEN_BITS = 6;
    // clk cycles between two left-word starts
    localparam int FRAME_CNT_BITS = 12;
    // Barrel shifter stages, enough for shifts of 0 to 31
    localparam int SHIFT_BITS = $clog2(MAX_WORD_BITS);

    //////////////////////////////////////////////////
    // Scalar types
    //////////////////////////////////////////////////

    typedef logic [MAX_WORD_BITS-1:0] raw_word_t;
    typedef logic [WORD_LEN_BITS-1:0] word_len_t;
    typedef logic [FRAME_CNT_BITS-1:0] frame_cnt_t;
    typedef logic signed [SAMPLE_BITS-1:0] sample_t;
    typedef logic [PWM_BITS-1:0] duty_t;

    //////////////////////////////////////////////////
    // Structs between blocks
    //////////////////////////////////////////////////

    // One received word, right-justified in data
    typedef struct packed {
        logic right;
        word_len_t len;
        raw_word_t data;
    } i2s_word_t;

    // Latest aligned sample per channel
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_sample_t;

endpackage

/* hw/i2s_rx.sv */
module i2s_rx import i2s_pwm_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       bclk,
    input  logic       lrclk,
    input  logic       sdata,
    output i2s_word_t  word,
    output logic       word_valid,
    output word_len_t  word_bits,
    output frame_cnt_t frame_cycles
);

    // Three-stage synchronizers, bit 0 is the newest sample
    logic [2:0] bclk_sync;
    logic [2:0] lrclk_sync;
    logic [2:0] sdata_sync;

    // Registered bclk rising edge, one bit tick
    logic bit_tick;
    // lrclk level seen at the previous tick
    logic lrclk_prev;

    logic lrclk_bit;
    logic sdata_bit;
    logic word_end;
    logic frame_start;

    raw_word_t shift_reg;
    raw_word_t word_data;
    word_len_t bit_cnt;
    word_len_t bit_cnt_inc;
    frame_cnt_t cycle_cnt;
    frame_cnt_t cycle_cnt_inc;

    //////////////////////////////////////////////////
    // Input sampling and bit tick
    //////////////////////////////////////////////////

    // lrclk and sdata go through the same depth as bclk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            sdata_sync <= '0;
            bit_tick   <= 1'b0;
        end else begin
            bclk_sync  <= {bclk_sync[1:0], bclk};
            lrclk_sync <= {lrclk_sync[1:0], lrclk};
            sdata_sync <= {sdata_sync[1:0], sdata};
            // Low, high, high from oldest to newest
            bit_tick   <= (bclk_sync == 3'b011);
        end
    end

    // Oldest stage was taken while bclk was already high
    assign lrclk_bit = lrclk_sync[2];
    assign sdata_bit = sdata_sync[2];

    // lrclk change closes the word, this tick carries its LSB
    assign word_end    = bit_tick && (lrclk_bit != lrclk_prev);
    // End of a right word is the start of the next left word
    assign frame_start = word_end && lrclk_prev;

    // New bit enters at the LSB end
    assign word_data   = {shift_reg[MAX_WORD_BITS-2:0], sdata_bit};
    // Saturating bit count, the closing bit included
    assign bit_cnt_inc = (bit_cnt == '1) ? bit_cnt : bit_cnt + 1'b1;

    //////////////////////////////////////////////////
    // Bit count and word strobe
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lrclk_prev <= 1'b0;
            bit_cnt    <= '0;
            word_bits  <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= word_end;
            if (bit_tick) begin
                lrclk_prev <= lrclk_bit;
                if (word_end) begin
                    bit_cnt   <= '0;
                    word_bits <= bit_cnt_inc;
                end else begin
                    bit_cnt <= bit_cnt_inc;
                end
            end
        end
    end

    // Shift register and word payload
    always_ff @(posedge clk) begin
        if (bit_tick) begin
            if (word_end) begin
                // Start the next word from an empty register
                shift_reg  <= '0;
                word.right <= lrclk_prev;
                word.len   <= bit_cnt_inc;
                word.data  <= word_data;
            end else begin
                shift_reg <= word_data;
            end
        end
    end

    //////////////////////////////////////////////////
    // Frame length in clk cycles
    //////////////////////////////////////////////////

    // Saturates on a stalled bus
    assign cycle_cnt_inc = (cycle_cnt == '1) ? cycle_cnt : cycle_cnt + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt    <= '0;
            frame_cycles <= '0;
        end else if (frame_start) begin
            cycle_cnt    <= '0;
            frame_cycles <= cycle_cnt_inc;
        end else begin
            cycle_cnt <= cycle_cnt_inc;
        end
    end

endmodule

/* hw/sample_align.sv */
module sample_align import i2s_pwm_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  i2s_word_t      word,
    input  logic           word_valid,
    output stereo_sample_t samples,
    output logic           left_valid,
    output logic           right_valid,
    output logic           format_err
);

    // Length inside MIN_WORD_BITS..MAX_WORD_BITS
    logic len_ok;
    // Left shift that puts the word MSB at bit 31
    logic [SHIFT_BITS-1:0] shift_amt;
    raw_word_t shifted;
    sample_t aligned;

    assign len_ok = (word.len >= word_len_t'(MIN_WORD_BITS)) &&
                    (word.len <= word_len_t'(MAX_WORD_BITS));

    // Only meaningful for legal lengths, range 0 to 24
    assign shift_amt = SHIFT_BITS'(word_len_t'(MAX_WORD_BITS) - word.len);

    //////////////////////////////////////////////////
    // Barrel shifter
    //////////////////////////////////////////////////

    // One stage per shift bit, stage i moves by 2**i
    always_comb begin
        shifted = word.data;
        for (int i = 0; i < SHIFT_BITS; i++) begin
            if (shift_amt[i]) begin
                shifted = shifted << (1 << i);
            end
        end
    end

    // Top bits form the sample, 32-bit words lose their low byte
    assign aligned = shifted[MAX_WORD_BITS-1 -: SAMPLE_BITS];

    //////////////////////////////////////////////////
    // Per-channel hold registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            samples     <= '0;
            left_valid  <= 1'b0;
            right_valid <= 1'b0;
            format_err  <= 1'b0;
        end else begin
            left_valid  <= word_valid && len_ok && !word.right;
            right_valid <= word_valid && len_ok && word.right;
            // Bad length keeps the held sample
            format_err  <= word_valid && !len_ok;
            if (word_valid && len_ok) begin
                if (word.right) begin
                    samples.right <= aligned;
                end else begin
                    samples.left <= aligned;
                end
            end
        end
    end

endmodule

/* hw/pwm_modulator.sv */
module pwm_modulator import i2s_pwm_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t sample,
    output logic    pwm
);

    // Period counter, one full sweep per PWM period
    duty_t cnt;
    // Compare value in use for the current period
    duty_t duty;
    // Offset-binary top byte of the incoming sample
    duty_t next_duty;
    // Last count of the period
    logic wrap;

    //////////////////////////////////////////////////
    // Duty from sample
    //////////////////////////////////////////////////

    // Sign bit inverted, so full negative is 0 and zero is midscale
    assign next_duty = {~sample[SAMPLE_BITS-1],
                        sample[SAMPLE_BITS-2 -: PWM_BITS-1]};

    assign wrap = (cnt == duty_t'(PWM_PERIOD - 1));

    //////////////////////////////////////////////////
    // Counter, compare and output
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt  <= '0;
            duty <= '0;
            pwm  <= 1'b0;
        end else begin
            if (wrap) begin
                cnt  <= '0;
                // Duty only changes at the period boundary
                duty <= next_duty;
            end else begin
                cnt <= cnt + 1'b1;
            end
            // Registered compare, high for exactly duty cycles per period
            // The last count never matches, so a period always ends low
            pwm <= (cnt < duty);
        end
    end

endmodule

/* hw/i2s_pwm_top.sv */
module i2s_pwm_top import i2s_pwm_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           bclk,
    input  logic           lrclk,
    input  logic           sdata,
    output stereo_sample_t samples,
    output logic           left_valid,
    output logic           right_valid,
    output logic           format_err,
    output word_len_t      word_bits,
    output frame_cnt_t     frame_cycles,
    output logic           pwm_left,
    output logic           pwm_right
);

    // Receiver to aligner
    i2s_word_t word;
    logic word_valid;

    //////////////////////////////////////////////////
    // Serial receiver
    //////////////////////////////////////////////////

    i2s_rx u_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .bclk         (bclk),
        .lrclk        (lrclk),
        .sdata        (sdata),
        .word         (word),
        .word_valid   (word_valid),
        .word_bits    (word_bits),
        .frame_cycles (frame_cycles)
    );

    // Word to 24-bit sample, held per channel
    sample_align u_align (
        .clk         (clk),
        .rst_n       (rst_n),
        .word        (word),
        .word_valid  (word_valid),
        .samples     (samples),
        .left_valid  (left_valid),
        .right_valid (right_valid),
        .format_err  (format_err)
    );

    //////////////////////////////////////////////////
    // Output stage
    //////////////////////////////////////////////////

    pwm_modulator pwm_l (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (samples.left),
        .pwm    (pwm_left)
    );

    pwm_modulator pwm_r (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (samples.right),
        .pwm    (pwm_right)
    );

endmodule

/* bench/i2s_pwm_checker.sv */
module i2s_pwm_checker import i2s_pwm_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  stereo_sample_t samples,
    input  logic           left_valid,
    input  logic           right_valid,
    input  logic           format_err,
    input  word_len_t      word_bits,
    input  frame_cnt_t     frame_cycles,
    input  logic           pwm_left,
    input  logic           pwm_right,
    input  logic           test_start,
    input  logic           test_done,
    input  int             test_id,
    input  stereo_sample_t exp_samples,
    input  word_len_t      exp_len,
    input  frame_cnt_t     exp_frame,
    input  logic           exp_err,
    input  int             exp_hold,
    output int             tests_passed,
    output int             tests_failed
);

    timeunit 1ns;
    timeprecision 1ps;

    // Right sample lands a few cycles after the start, then one period to reload
    localparam int SETTLE_CYCLES = PWM_PERIOD + 16;

    // Expected values of the running test
    logic active;
    stereo_sample_t cur_samples;
    word_len_t cur_len;
    frame_cnt_t cur_frame;
    logic cur_err;
    int cur_hold;
    int cur_id;
    duty_t cur_duty [2];

    int cyc;
    int errs;
    int n_left;
    int n_right;
    int n_err;

    // PWM pulse tracking, index 0 is left
    logic [1:0] pwm_prev;
    int hi_len [2];
    int rise_at [2];
    int n_pulse [2];

    task automatic report_wrong(input string msg);
        $display("[FAIL] %0d ns: test %0d %s", $time, cur_id, msg);
        errs++;
    endtask

    task automatic check_status(input string what);
        if (word_bits != cur_len) begin
            report_wrong($sformatf("%s word_bits %0d, expected %0d", what, word_bits, cur_len));
        end
        if (frame_cycles != cur_frame) begin
            report_wrong($sformatf("%s frame_cycles %0d, expected %0d",
                                   what, frame_cycles, cur_frame));
        end
    endtask

    //////////////////////////////////////////////////
    // Per-test bookkeeping
    //////////////////////////////////////////////////

    task automatic start_test();
        active      = 1'b1;
        cur_samples = exp_samples;
        cur_len     = exp_len;
        cur_frame   = exp_frame;
        cur_err     = exp_err;
        cur_hold    = exp_hold;
        cur_id      = test_id;
        // Offset binary, top byte with the sign flipped
        cur_duty[0] = exp_samples.left[23:16] ^ 8'h80;
        cur_duty[1] = exp_samples.right[23:16] ^ 8'h80;
        cyc     = 0;
        errs    = 0;
        n_left  = 0;
        n_right = 0;
        n_err   = 0;
        rise_at = '{0, 0};
        n_pulse = '{0, 0};
    endtask

    task automatic count_strobes(input string what, input int seen, input int want);
        if (seen != want) begin
            $display("Test %0d saw %0d %s, expected %0d", cur_id, seen, what, want);
            errs++;
        end
    endtask

    task automatic finish_test();
        int words;
        bit long_hold;
        logic [1:0] level;
        active    = 1'b0;
        level     = {pwm_right, pwm_left};
        words     = cur_err ? 0 : cur_hold;
        long_hold = cur_hold >= 4 && cur_hold * int'(cur_frame) >= 4 * PWM_PERIOD;
        if (samples != cur_samples) begin
            report_wrong($sformatf("held samples %h, expected %h", samples, cur_samples));
        end
        count_strobes("left sample strobes", n_left, words);
        count_strobes("right sample strobes", n_right, words);
        count_strobes("format errors", n_err, cur_err ? 2 * cur_hold : 0);
        for (int c = 0; c < 2; c++) begin
            if (long_hold && cur_duty[c] != 0 && n_pulse[c] == 0) begin
                $display("Test %0d saw no PWM pulse on the %s output", cur_id,
                         c ? "right" : "left");
                errs++;
            end
            // Duty 0 keeps the output low all the time
            if (long_hold && cur_duty[c] == 0 && level[c]) begin
                $display("Test %0d saw the %s PWM output high with a duty of 0", cur_id,
                         c ? "right" : "left");
                errs++;
            end
        end
        if (errs == 0) begin
            tests_passed++;
            $display("Test %0d: %0d-bit words, %0d frames, ok", cur_id, cur_len, cur_hold);
        end else begin
            tests_failed++;
            $display("Test %0d: %0d-bit words, %0d frames, %0d errors",
                     cur_id, cur_len, cur_hold, errs);
        end
    endtask

    //////////////////////////////////////////////////
    // Strobe and PWM monitors
    //////////////////////////////////////////////////

    task automatic watch_strobes();
        if (left_valid) begin
            n_left++;
            if (cur_err) begin
                report_wrong("left strobe on an illegal word length");
            end else if (samples.left != cur_samples.left) begin
                report_wrong($sformatf("left sample %h, expected %h",
                                       samples.left, cur_samples.left));
            end
            check_status("left word");
        end
        if (right_valid) begin
            n_right++;
            if (cur_err) begin
                report_wrong("right strobe on an illegal word length");
            end else if (samples.right != cur_samples.right) begin
                report_wrong($sformatf("right sample %h, expected %h",
                                       samples.right, cur_samples.right));
            end
            check_status("right word");
        end
        if (format_err) begin
            n_err++;
            if (!cur_err) begin
                report_wrong("format_err on a legal word length");
            end
            check_status("bad word");
        end
    endtask

    task automatic watch_pwm();
        logic [1:0] now;
        now = {pwm_right, pwm_left};
        for (int c = 0; c < 2; c++) begin
            if (now[c] && !pwm_prev[c]) begin
                hi_len[c]  = 1;
                rise_at[c] = cyc;
            end else if (now[c]) begin
                hi_len[c]++;
            end else if (pwm_prev[c] && rise_at[c] > SETTLE_CYCLES) begin
                // Whole pulse inside the settled part of the test
                n_pulse[c]++;
                if (hi_len[c] != int'(cur_duty[c])) begin
                    report_wrong($sformatf("%s PWM high for %0d cycles, expected %0d",
                                           c ? "right" : "left", hi_len[c], cur_duty[c]));
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            active       = 1'b0;
            pwm_prev     = '0;
            hi_len       = '{0, 0};
            rise_at      = '{0, 0};
            tests_passed = 0;
            tests_failed = 0;
        end else begin
            if (test_start) begin
                start_test();
            end
            if (active) begin
                cyc++;
                watch_strobes();
                watch_pwm();
                if (test_done) begin
                    finish_test();
                end
            end
            pwm_prev = {pwm_right, pwm_left};
        end
    end

endmodule

/* bench/tb_i2s_pwm.sv */
module tb_i2s_pwm import i2s_pwm_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS = 4;
    // clk cycles per bclk period, half low and half high
    localparam int BCLK_CYCLES = 8;
    // Slack on top of the transmitted frames
    localparam int MARGIN_NS = 20000;

    logic clk;
    logic rst_n;
    logic bclk;
    logic lrclk;
    logic sdata;

    stereo_sample_t samples;
    logic left_valid;
    logic right_valid;
    logic format_err;
    word_len_t word_bits;
    frame_cnt_t frame_cycles;
    logic pwm_left;
    logic pwm_right;

    // Test strobes and expected values for the checker
    logic test_start;
    logic test_done;
    int test_id;
    stereo_sample_t exp_samples;
    word_len_t exp_len;
    frame_cnt_t exp_frame;
    logic exp_err;
    int exp_hold;
    int tests_passed;
    int tests_failed;

    // One entry per stimulus line
    int q_len[$];
    int q_hold[$];
    logic [31:0] q_left[$];
    logic [31:0] q_right[$];

    // Sample the DUT should hold for each channel
    stereo_sample_t held;
    // LSB of the previous word, sent in the first slot of the next one
    logic carry;
    int limit_ns;
    int unsigned seed;

    i2s_pwm_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .bclk         (bclk),
        .lrclk        (lrclk),
        .sdata        (sdata),
        .samples      (samples),
        .left_valid   (left_valid),
        .right_valid  (right_valid),
        .format_err   (format_err),
        .word_bits    (word_bits),
        .frame_cycles (frame_cycles),
        .pwm_left     (pwm_left),
        .pwm_right    (pwm_right)
    );

    i2s_pwm_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .samples      (samples),
        .left_valid   (left_valid),
        .right_valid  (right_valid),
        .format_err   (format_err),
        .word_bits    (word_bits),
        .frame_cycles (frame_cycles),
        .pwm_left     (pwm_left),
        .pwm_right    (pwm_right),
        .test_start   (test_start),
        .test_done    (test_done),
        .test_id      (test_id),
        .exp_samples  (exp_samples),
        .exp_len      (exp_len),
        .exp_frame    (exp_frame),
        .exp_err      (exp_err),
        .exp_hold     (exp_hold),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Expected values and stimulus file
    //////////////////////////////////////////////////

    // Left-justify in 32 bits, top 24 bits are the sample
    function automatic sample_t expected_sample(input int len, input logic [31:0] val);
        logic [31:0] justified;
        justified = val << (MAX_WORD_BITS - len);
        return justified[31:8];
    endfunction

    // Hex token or R, cut down to len bits
    function automatic logic [31:0] word_value(input string tok, input int len);
        logic [31:0] v;
        logic [63:0] mask;
        v = '0;
        if (tok == "R") begin
            v = $urandom();
        end else begin
            void'($sscanf(tok, "%h", v));
        end
        mask = (64'd1 << len) - 64'd1;
        return v & mask[31:0];
    endfunction

    task automatic load_tests(output bit ok);
        int fd;
        int n;
        int len;
        int hold;
        string line;
        string ltok;
        string rtok;
        fd = $fopen("bench/i2s_stimulus.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Comment and blank lines give fewer than four fields
                n = $sscanf(line, "%d %s %s %d", len, ltok, rtok, hold);
                if (n == 4) begin
                    q_len.push_back(len);
                    q_hold.push_back(hold);
                    q_left.push_back(word_value(ltok, len));
                    q_right.push_back(word_value(rtok, len));
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////
    // I2S serializer
    //////////////////////////////////////////////////

    // One bclk period, lrclk and sdata change with the falling bclk
    task automatic send_slot(input logic lr, input logic bit_val);
        @(negedge clk);
        bclk  = 1'b0;
        lrclk = lr;
        sdata = bit_val;
        // Test strobes last a single clk cycle
        test_start = 1'b0;
        test_done  = 1'b0;
        repeat (BCLK_CYCLES / 2) @(negedge clk);
        bclk = 1'b1;
        repeat (BCLK_CYCLES / 2 - 1) @(negedge clk);
    endtask

    // Left then right, MSB first with the one-bit delay
    task automatic send_frame(input int len, input logic [31:0] lval, input logic [31:0] rval);
        logic [31:0] val;
        for (int ch = 0; ch < 2; ch++) begin
            val = (ch == 0) ? lval : rval;
            for (int k = 0; k < len; k++) begin
                if (k == 0) begin
                    send_slot(ch[0], carry);
                end else begin
                    send_slot(ch[0], val[len - k]);
                end
            end
            carry = val[0];
        end
    endtask

    task automatic run_test(input int idx);
        int len;
        len = q_len[idx];
        // Warm-up frame settles word length, frame count and samples
        send_frame(len, q_left[idx], q_right[idx]);
        exp_err = !(len >= MIN_WORD_BITS && len <= MAX_WORD_BITS);
        if (!exp_err) begin
            held.left  = expected_sample(len, q_left[idx]);
            held.right = expected_sample(len, q_right[idx]);
        end
        exp_samples = held;
        exp_len     = word_len_t'(len);
        exp_frame   = frame_cnt_t'(2 * len * BCLK_CYCLES);
        exp_hold    = q_hold[idx];
        test_id     = idx;
        test_start  = 1'b1;
        repeat (q_hold[idx]) send_frame(len, q_left[idx], q_right[idx]);
        test_done = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        bit loaded;
        rst_n       = 1'b0;
        bclk        = 1'b0;
        lrclk       = 1'b0;
        sdata       = 1'b0;
        test_start  = 1'b0;
        test_done   = 1'b0;
        test_id     = 0;
        exp_samples = '0;
        exp_len     = '0;
        exp_frame   = '0;
        exp_err     = 1'b0;
        exp_hold    = 0;
        held        = '0;
        carry       = 1'b0;
        limit_ns    = 0;
        seed        = 32'haf7d238d;
        void'($urandom(seed));
        load_tests(loaded);
        if (!loaded) begin
            $display("Cannot open bench/i2s_stimulus.txt");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            foreach (q_len[i]) begin
                limit_ns += (q_hold[i] + 1) * 2 * q_len[i] * BCLK_CYCLES * CLK_NS;
            end
            limit_ns += MARGIN_NS;
            repeat (4) @(negedge clk);
            rst_n = 1'b1;
            // One right-channel bit so the first frame start is seen
            send_slot(1'b1, 1'b0);
            foreach (q_len[i]) begin
                run_test(i);
            end
            @(negedge clk);
            test_done = 1'b0;
            repeat (4) @(negedge clk);
            $display("Tests passed: %0d, failed: %0d, total: %0d",
                     tests_passed, tests_failed, q_len.size());
            if (q_len.size() > 0 && tests_failed == 0 && tests_passed == q_len.size()) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Timeout: tests did not finish within %0d ns", limit_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* bench/i2s_stimulus.txt */
# word_len  left  right  hold_frames
# word_len and hold_frames in decimal, left and right in hex, R draws a random value
24 123456 EDCBA9 4
24 7FFFFF 800000 4
24 800000 7FFFFF 4
24 000000 400000 4
24 R R 4
24 R R 5
16 1234 8000 6
16 7FFF R 4
16 R R 4
32 12345678 87654321 4
32 R 00FF00FF 4
32 80000000 7FFFFFFF 4
8 7F 80 8
8 R C3 8
6 15 2A 12
24 654321 ABCDEF 4
6 3F 00 12
12 ABC 123 6
20 R R 4
28 R 8000000 4
24 000000 000000 4

/* build.f */
hw/i2s_pwm_pkg.sv
hw/i2s_rx.sv
hw/sample_align.sv
hw/pwm_modulator.sv
hw/i2s_pwm_top.sv
bench/i2s_pwm_checker.sv
bench/tb_i2s_pwm.sv

/* Makefile */
# Verilator build and run of the I2S to PWM testbench
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module tb_i2s_pwm -f build.f

# The stimulus path is relative to the project root
run: build
	./obj_dir/Vtb_i2s_pwm | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "No result in $(LOG)"; exit 1)

lint:
	verilator --lint-only -Wall --top-module i2s_pwm_top \
		hw/i2s_pwm_pkg.sv hw/i2s_rx.sv hw/sample_align.sv \
		hw/pwm_modulator.sv hw/i2s_pwm_top.sv

clean:
	rm -rf obj_dir $(LOG)
